//--- logic/noc_pkg.sv
package noc_pkg;

	//////////////////////////////////////////////////////////////
	// flit layout from the router
	//
	//   [ payload 10 | tail 1 ]
	//
	// headers arrive already stripped to zero, only the tail matters
	//////////////////////////////////////////////////////////////

	localparam int FLIT_W    = 11; // one router flit
	localparam int PAYLOAD_W = 10; // payload bits above the tail
	localparam int CORE_W    = 30; // routed core word, code + data
	localparam int FIFO_DEPTH = 8; // flits buffered per router port
	localparam int NUM_PORTS = 2;  // router ports feeding the core

	//////////////////////////////////////////////////////////////
	// core word layout
	//
	//   [ code 6 | data 24 ]
	//
	// the core format is 32 bits wide, top two bits are always zero
	// and never travel on any port
	//////////////////////////////////////////////////////////////

	typedef logic [FLIT_W-1:0]    flit_t;      // bit 0 is the tail
	typedef logic [PAYLOAD_W-1:0] payload_t;   // ten bits from one flit
	typedef logic [CORE_W-1:0]    core_word_t; // three payloads packed
	typedef logic [0:0]           port_id_t;   // source router port

	// deserializer walk through a worm
	typedef enum logic [2:0] {
		hunt_header, // waiting for the header flit, dropped on pop
		take_hi,     // first data flit of a group
		take_mid,    // second data flit
		take_lo,     // third data flit, its tail decides what follows
		hold_word    // word presented until the core acks it
	} deser_state_t;

endpackage

//--- logic/flit_fifo.sv
`timescale 1ns/1ps

// show-ahead flit buffer for one router port
module flit_fifo (
	input  logic           clk,
	input  logic           reset,
	input  logic           wr,      // one pulse per flit from the router
	input  noc_pkg::flit_t wr_data,
	input  logic           rd_req,  // pop the flit shown on rd_data
	output noc_pkg::flit_t rd_data,
	output logic           empty,
	output logic           full
);
	import noc_pkg::*;

	//////////////////////////////////////////////////////////////
	// storage and pointers
	//////////////////////////////////////////////////////////////

	flit_t mem [FIFO_DEPTH];                // circular buffer

	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;  // next slot to fill
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;  // oldest flit
	logic [$clog2(FIFO_DEPTH):0]   count;   // flits held, 0..FIFO_DEPTH

	logic do_wr; // accepted write
	logic do_rd; // accepted pop

	// step a pointer and wrap at the depth
	function automatic logic [$clog2(FIFO_DEPTH)-1:0] ptr_step(
		input logic [$clog2(FIFO_DEPTH)-1:0] ptr
	);
		if (ptr == FIFO_DEPTH - 1)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = (count == 0);
	assign full  = (count == FIFO_DEPTH);

	assign do_wr = wr && !full;      // router must not write while full
	assign do_rd = rd_req && !empty; // pop only what is there

	assign rd_data = mem[rd_ptr];    // head flit always visible

	//////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= ptr_step(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_step(rd_ptr);
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1; // fill
				2'b01: count <= count - 1'b1; // drain
				default: count <= count;      // both or neither
			endcase
		end
	end

	// flit storage written on accepted pushes
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

//--- logic/flit_deserializer.sv
`timescale 1ns/1ps

// packs groups of three data flits into one core word
module flit_deserializer (
	input  logic                clk,
	input  logic                reset,
	input  noc_pkg::flit_t      rd_data,    // head of the flit FIFO
	input  logic                empty,      // FIFO has nothing to show
	output logic                rd_req,     // pop request to the FIFO
	output noc_pkg::core_word_t word,       // assembled word for the core
	output logic                word_valid, // level, held until word_ack
	input  logic                word_ack    // one-cycle pulse from the arbiter
);
	import noc_pkg::*;

	//////////////////////////////////////////////////////////////
	// state and assembly register
	//////////////////////////////////////////////////////////////

	deser_state_t state;
	deser_state_t state_next;

	core_word_t asm_word;  // hi, mid and lo payloads land here
	logic       last_tail; // tail of the third flit in the group

	payload_t payload;     // payload part of the head flit
	logic     tail;        // tail bit of the head flit

	assign payload = rd_data[FLIT_W-1 -: PAYLOAD_W]; // bits above the tail
	assign tail    = rd_data[0];

	assign word       = asm_word;
	assign word_valid = (state == hold_word);

	//////////////////////////////////////////////////////////////
	// next state and pop
	//////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		rd_req     = 1'b0;
		case (state)
			hunt_header: begin
				// header is zero, pop and throw it away
				if (!empty) begin
					rd_req     = 1'b1;
					state_next = take_hi;
				end
			end
			take_hi: begin
				if (!empty) begin
					rd_req     = 1'b1;
					state_next = take_mid;
				end
			end
			take_mid: begin
				if (!empty) begin
					rd_req     = 1'b1;
					state_next = take_lo;
				end
			end
			take_lo: begin
				if (!empty) begin
					rd_req     = 1'b1;
					state_next = hold_word; // valid on the next cycle
				end
			end
			hold_word: begin
				// no pops while the word waits on the core bus
				if (word_ack)
					state_next = last_tail ? hunt_header : take_hi;
			end
			default: state_next = hunt_header;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state     <= hunt_header;
			last_tail <= 1'b0;
		end else begin
			state <= state_next;
			if (rd_req && state == take_lo)
				last_tail <= tail; // only the third flit can end a worm
		end
	end

	//////////////////////////////////////////////////////////////
	// word assembly
	//////////////////////////////////////////////////////////////

	// first flit gives the top ten bits
	always_ff @(posedge clk) begin
		if (rd_req) begin
			case (state)
				take_hi:  asm_word[CORE_W-1 -: PAYLOAD_W]           <= payload;
				take_mid: asm_word[CORE_W-1-PAYLOAD_W -: PAYLOAD_W] <= payload;
				take_lo:  asm_word[PAYLOAD_W-1:0]                   <= payload;
				default:  asm_word <= asm_word; // header pop leaves it alone
			endcase
		end
	end

endmodule

//--- logic/core_bus_arbiter.sv
`timescale 1ns/1ps

// round-robin share of the core bus between the two deserializers
module core_bus_arbiter (
	input  logic                clk,
	input  logic                reset,
	input  noc_pkg::core_word_t word_0,
	input  noc_pkg::core_word_t word_1,
	input  logic                valid_0,
	input  logic                valid_1,
	output logic                ack_0,
	output logic                ack_1,
	output noc_pkg::core_word_t core_word,
	output noc_pkg::port_id_t   core_src,
	output logic                core_valid,
	input  logic                core_ack
);
	import noc_pkg::*;

	//////////////////////////////////////////////////////////////
	// grant selection
	//////////////////////////////////////////////////////////////

	logic [NUM_PORTS-1:0] req;       // held words, one bit per port
	port_id_t             grant;     // port on the bus this cycle
	port_id_t             last_port; // port of the previous transfer
	port_id_t             lock_port; // port pinned while the core stalls
	logic                 lock;      // a word is waiting on the bus

	assign req = {valid_1, valid_0};

	always_comb begin
		if (lock)
			grant = lock_port;          // never move a waiting word
		else if (req[0] && req[1])
			grant = ~last_port;         // both ready, other one's turn
		else if (req[1])
			grant = 1'b1;
		else
			grant = 1'b0;               // port 0 or idle
	end

	//////////////////////////////////////////////////////////////
	// bus mux and ack return
	//////////////////////////////////////////////////////////////

	assign core_valid = req[grant];
	assign core_word  = (grant == 1'b1) ? word_1 : word_0;
	assign core_src   = grant;

	// ack only reaches the peer that owns the bus
	assign ack_0 = core_ack && core_valid && (grant == 1'b0);
	assign ack_1 = core_ack && core_valid && (grant == 1'b1);

	always_ff @(posedge clk) begin
		if (!reset) begin
			last_port <= 1'b1; // port 0 goes first
			lock_port <= 1'b0;
			lock      <= 1'b0;
		end else begin
			if (core_valid && core_ack) begin
				last_port <= grant; // transfer done, release the bus
				lock      <= 1'b0;
			end else if (core_valid) begin
				lock_port <= grant; // core stalling, pin the grant
				lock      <= 1'b1;
			end
		end
	end

endmodule

//--- logic/net_ingress.sv
`timescale 1ns/1ps

// router ingress, two flit ports into one core bus
module net_ingress (
	input  logic                clk,
	input  logic                reset,
	input  logic                flit_wr_0,
	input  logic                flit_wr_1,
	input  noc_pkg::flit_t      flit_0,
	input  noc_pkg::flit_t      flit_1,
	output logic                fifo_full_0, // router holds off while high
	output logic                fifo_full_1,
	output noc_pkg::core_word_t core_word,
	output noc_pkg::port_id_t   core_src,
	output logic                core_valid,
	input  logic                core_ack
);
	import noc_pkg::*;

	//////////////////////////////////////////////////////////////
	// port 0 and port 1 paths
	//////////////////////////////////////////////////////////////

	flit_t      rd_data_0, rd_data_1;     // FIFO heads
	logic       empty_0, empty_1;
	logic       rd_req_0, rd_req_1;
	core_word_t word_0, word_1;           // held words toward the arbiter
	logic       word_valid_0, word_valid_1;
	logic       word_ack_0, word_ack_1;

	flit_fifo fifo_0_i (
		.clk(clk), .reset(reset),
		.wr(flit_wr_0), .wr_data(flit_0),
		.rd_req(rd_req_0), .rd_data(rd_data_0),
		.empty(empty_0), .full(fifo_full_0)
	);

	flit_fifo fifo_1_i (
		.clk(clk), .reset(reset),
		.wr(flit_wr_1), .wr_data(flit_1),
		.rd_req(rd_req_1), .rd_data(rd_data_1),
		.empty(empty_1), .full(fifo_full_1)
	);

	flit_deserializer deser_0_i (
		.clk(clk), .reset(reset),
		.rd_data(rd_data_0), .empty(empty_0), .rd_req(rd_req_0),
		.word(word_0), .word_valid(word_valid_0), .word_ack(word_ack_0)
	);

	flit_deserializer deser_1_i (
		.clk(clk), .reset(reset),
		.rd_data(rd_data_1), .empty(empty_1), .rd_req(rd_req_1),
		.word(word_1), .word_valid(word_valid_1), .word_ack(word_ack_1)
	);

	// shared core bus
	core_bus_arbiter arbiter_i (
		.clk(clk), .reset(reset),
		.word_0(word_0), .word_1(word_1),
		.valid_0(word_valid_0), .valid_1(word_valid_1),
		.ack_0(word_ack_0), .ack_1(word_ack_1),
		.core_word(core_word), .core_src(core_src),
		.core_valid(core_valid), .core_ack(core_ack)
	);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

// free-running testbench clock, 4 ns period
module tb_clock (
	output logic clk
);

	//////////////////////////////////////////////////////////////
	// 2 ns high, 2 ns low
	//////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;              // known level before the first edge
		forever begin
			#2 clk = ~clk;       // half period
		end
	end

endmodule

//--- tests/net_ingress_tb.sv
`timescale 1ns/1ps

// table-driven testbench for the two-port ingress
module net_ingress_tb;
	import noc_pkg::*;

	logic       clk;
	logic       reset;
	logic       flit_wr_0, flit_wr_1;
	flit_t      flit_0, flit_1;
	logic       fifo_full_0, fifo_full_1;
	core_word_t core_word;
	port_id_t   core_src;
	logic       core_valid;
	logic       core_ack;

	tb_clock clock_i (.clk(clk));

	net_ingress net_ingress_i (
		.clk(clk), .reset(reset),
		.flit_wr_0(flit_wr_0), .flit_wr_1(flit_wr_1),
		.flit_0(flit_0), .flit_1(flit_1),
		.fifo_full_0(fifo_full_0), .fifo_full_1(fifo_full_1),
		.core_word(core_word), .core_src(core_src),
		.core_valid(core_valid), .core_ack(core_ack)
	);

	//////////////////////////////////////////////////////////////
	// worm table over one flat list of words
	//////////////////////////////////////////////////////////////

	int         worm_test [$];  // test the worm belongs to
	int         worm_port [$];
	int         worm_len [$];   // core words in the worm
	int         worm_first [$]; // index of its first word
	core_word_t table_words [$];

	core_word_t exp_q0 [$];     // scoreboard per port
	core_word_t exp_q1 [$];
	core_word_t exp_word;
	int         sent [NUM_PORTS]; // flits written in the current test

	integer   seed;
	logic     ack_hold;           // sink keeps core_ack low
	logic     expect_alt;         // last transfer was contested
	port_id_t alt_src;            // port that must come next
	int       errors = 0;
	int       checks = 0;
	int       tests_run = 0;
	int       tests_failed = 0;
	int       contested = 0;
	int       cycle_count = 0;
	int       cycle_limit = 0;

	task automatic add_worm(input int t, input int p);
		worm_test.push_back(t);
		worm_port.push_back(p);
		worm_len.push_back(0);
		worm_first.push_back(table_words.size());
	endtask

	task automatic add_word(input core_word_t w);
		table_words.push_back(w);
		worm_len[worm_len.size()-1]++;
	endtask

	task automatic load_table();
		add_worm(2, 0);          // single word with the tail on its third flit
		add_word(30'h1234_5678);
		add_worm(3, 1);          // tail clear on the first two groups
		add_word(30'h3FF0_0001);
		add_word(30'h2AAA_5555);
		add_word(30'h0000_03FF);
		add_worm(3, 1);          // next header must be dropped
		add_word(30'h3C3C_C3C3);
		add_worm(4, 0);
		add_word(30'h0ABC_DEF0);
		add_word(30'h1111_2222);
		add_word(30'h3333_0444);
		add_worm(4, 1);
		add_word(30'h2468_ACE0);
		add_word(30'h1357_9BDF);
		add_worm(5, 0);          // long enough to fill the FIFO behind a held word
		add_word(30'h3FFF_FFFF);
		add_word(30'h0000_0000);
		add_word(30'h2000_0001);
		add_word(30'h1E1E_1E1E);
	endtask

	function automatic int count_flits();
		int total;
		total = 0;
		foreach (worm_len[w])
			total += 1 + 3 * worm_len[w]; // header plus three per word
		return total;
	endfunction

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		errors++;
		$display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, expected);
	endtask

	//////////////////////////////////////////////////////////////
	// router side flit driver
	//////////////////////////////////////////////////////////////

	task automatic send_worm(input int w);
		int         p;
		int         nflits;
		int         k;
		int         gap;
		flit_t      f;
		core_word_t wd;
		p      = worm_port[w];
		nflits = 1 + 3 * worm_len[w];
		for (k = 0; k < nflits; k++) begin
			f = '0;                                // header is all zero
			if (k > 0) begin
				wd = table_words[worm_first[w] + (k - 1) / 3];
				// high payload first with the tail only on the very last flit
				f = {wd[CORE_W-1-PAYLOAD_W*((k-1)%3) -: PAYLOAD_W], k == nflits - 1};
			end
			gap = $random(seed) & 3;
			repeat (gap) @(posedge clk);
			do @(negedge clk); while (p == 0 ? fifo_full_0 : fifo_full_1); // obey full
			@(posedge clk);
			if (p == 0) begin
				flit_0    <= f;
				flit_wr_0 <= 1'b1;
			end else begin
				flit_1    <= f;
				flit_wr_1 <= 1'b1;
			end
			@(posedge clk);                        // write lands here
			if (p == 0)
				flit_wr_0 <= 1'b0;
			else
				flit_wr_1 <= 1'b0;
			sent[p]++;
		end
	endtask

	// worms of one port in table order
	task automatic send_port(input int t, input int p);
		foreach (worm_test[w])
			if (worm_test[w] == t && worm_port[w] == p)
				send_worm(w);
	endtask

	// both first words held on the bus before the core starts taking them
	task automatic release_when_both_held();
		while (sent[0] < 4 || sent[1] < 4)
			@(negedge clk);
		repeat (2) @(negedge clk);
		ack_hold = 1'b0;
	endtask

	// port 0 stalled with one word held and FIFO_DEPTH flits behind it
	task automatic hold_check();
		core_word_t first_word;
		int         i;
		first_word = exp_q0[0];                    // nothing can leave while stalled
		while (sent[0] < 4 + FIFO_DEPTH)
			@(negedge clk);
		checks += 2;
		if (fifo_full_0 !== 1'b1)
			value_error("fifo_full_0", fifo_full_0, 1);
		if (core_valid !== 1'b1)
			value_error("core_valid", core_valid, 1);
		for (i = 0; i < 20; i++) begin             // bus must not move while stalled
			checks += 2;
			if (core_word !== first_word)
				value_error("core_word", core_word, first_word);
			if (core_src !== 1'b0)
				value_error("core_src", core_src, 0);
			@(negedge clk);
		end
		ack_hold = 1'b0;                           // let the core drain
	endtask

	task automatic finish_test(input int t, input string name, input int start_errors);
		tests_run++;
		if (errors != start_errors)
			tests_failed++;
		$display("test %0d %-26s %s, %0d errors, %0d contested transfers", t, name,
			(errors == start_errors) ? "ok" : "failing", errors - start_errors, contested);
	endtask

	task automatic run_test(input int t, input string name, input logic hold,
			input logic contend);
		int start_errors;
		start_errors = errors;
		contested    = 0;
		sent[0]      = 0;
		sent[1]      = 0;
		foreach (worm_test[w]) begin
			if (worm_test[w] == t) begin
				for (int i = 0; i < worm_len[w]; i++) begin
					if (worm_port[w] == 0)
						exp_q0.push_back(table_words[worm_first[w] + i]);
					else
						exp_q1.push_back(table_words[worm_first[w] + i]);
				end
			end
		end
		ack_hold = hold || contend;                // core stalls until released
		if (hold) begin
			fork
				send_port(t, 0);
				hold_check();
			join
		end else begin
			fork
				send_port(t, 0);
				send_port(t, 1);
				if (contend)
					release_when_both_held();
			join
		end
		while (exp_q0.size() != 0 || exp_q1.size() != 0)
			@(negedge clk);
		repeat (8) @(negedge clk);
		checks++;
		if (core_valid !== 1'b0) begin
			errors++;
			$display("a word is still waiting on the core bus after test %0d", t);
		end
		if (contend) begin
			checks++;
			if (contested == 0) begin
				errors++;
				$display("no transfer in test %0d had both ports holding a word", t);
			end
		end
		finish_test(t, name, start_errors);
	endtask

	//////////////////////////////////////////////////////////////
	// core sink, scoreboard and timeout
	//////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (ack_hold)
			core_ack <= 1'b0;
		else
			core_ack <= (($random(seed) & 3) != 0); // ack about three cycles in four
	end

	always @(negedge clk) begin
		if (reset && core_valid && core_ack) begin  // transfer at the next edge
			checks++;
			if (expect_alt && core_src !== alt_src)
				value_error("core_src", core_src, alt_src);
			expect_alt = net_ingress_i.word_valid_0 && net_ingress_i.word_valid_1;
			alt_src    = ~core_src;
			if (expect_alt)
				contested++;
			if ((core_src == 1'b0 && exp_q0.size() == 0) ||
					(core_src == 1'b1 && exp_q1.size() == 0)) begin
				errors++;
				$display("word %h arrived from port %0d with nothing expected there",
					core_word, core_src);
			end else begin
				exp_word = (core_src == 1'b0) ? exp_q0.pop_front() : exp_q1.pop_front();
				if (core_word !== exp_word)
					value_error("core_word", core_word, exp_word);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("run timed out after %0d cycles with %0d words still outstanding",
				cycle_count, exp_q0.size() + exp_q1.size());
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////

	initial begin
		seed       = 32'h4072;
		ack_hold   = 1'b1;
		expect_alt = 1'b0;
		alt_src    = 1'b0;
		reset      = 1'b0;
		core_ack   = 1'b0;
		flit_wr_0  = 1'b0;
		flit_wr_1  = 1'b0;
		flit_0     = '0;
		flit_1     = '0;
		load_table();
		cycle_limit = 8 * count_flits() + 200;
		repeat (10) @(posedge clk);
		reset <= 1'b1;

		repeat (3) @(negedge clk);                 // idle levels before any flit is written
		checks += 3;
		if (core_valid !== 1'b0)
			value_error("core_valid", core_valid, 0);
		if (fifo_full_0 !== 1'b0)
			value_error("fifo_full_0", fifo_full_0, 0);
		if (fifo_full_1 !== 1'b0)
			value_error("fifo_full_1", fifo_full_1, 0);
		finish_test(1, "reset levels", 0);

		run_test(2, "one word on port 0", 1'b0, 1'b0);
		run_test(3, "two worms on port 1", 1'b0, 1'b0);
		run_test(4, "both ports at once", 1'b0, 1'b1);
		run_test(5, "core back-pressure", 1'b1, 1'b0);

		$display("tests %0d, failing %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- sim.f
logic/noc_pkg.sv
logic/flit_fifo.sv
logic/flit_deserializer.sv
logic/core_bus_arbiter.sv
logic/net_ingress.sv
tests/tb_clock.sv
tests/net_ingress_tb.sv

//--- Bender.yml
package:
  name: net_ingress

sources:
  - files:
      - logic/noc_pkg.sv
      - logic/flit_fifo.sv
      - logic/flit_deserializer.sv
      - logic/core_bus_arbiter.sv
      - logic/net_ingress.sv
  - target: simulation
    files:
      - tests/tb_clock.sv
      - tests/net_ingress_tb.sv
